// File: hw/alu.sv
`timescale 1ns/1ps

module alu import exu_pkg::*; (
  input  alu_op_t     op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] result
);

  logic lt_s;
  logic lt_u;

  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << b[4:0];
      alu_slt:    result = {31'd0, lt_s};
      alu_sltu:   result = {31'd0, lt_u};
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> b[4:0];
      alu_sra:    result = $unsigned($signed(a) >>> b[4:0]);
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b; // lui and csr data.
      alu_eq:     result = {31'd0, a == b};
      alu_ne:     result = {31'd0, a != b};
      alu_lt:     result = {31'd0, lt_s};
      alu_ge:     result = {31'd0, !lt_s};
      alu_ltu:    result = {31'd0, lt_u};
      alu_geu:    result = {31'd0, !lt_u};
      default:    result = 32'd0;
    endcase
  end

endmodule

// File: hw/exu_pkg.sv
package exu_pkg;

  localparam logic [31:0] reset_pc = 32'h0000_0000;

  // rv32i major opcodes.
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_system = 7'b1110011;

  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_pass_b,
    alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu // compares give 0 or 1.
  } alu_op_t;

  typedef enum logic [1:0] {npc_seq, npc_jal, npc_jalr, npc_branch} npc_sel_t;
  typedef enum logic [1:0] {wdata_alu, wdata_snpc, wdata_dnpc, wdata_csr} wdata_sel_t;
  typedef enum logic [1:0] {op1_src1, op1_pc, op1_zero} op1_sel_t;
  typedef enum logic [1:0] {op2_src2, op2_imm, op2_csr} op2_sel_t;
  typedef enum logic [1:0] {csr_none, csr_write, csr_set, csr_clear} csr_op_t; // same as funct3[1:0].

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] csr_src;
  } inst_in_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] imm;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] csr_src;
    alu_op_t     alu_op;
    op1_sel_t    op1_sel;
    op2_sel_t    op2_sel;
    npc_sel_t    npc_sel;
    wdata_sel_t  wdata_sel;
    csr_op_t     csr_op;
    logic [4:0]  rd;
  } exec_req_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] npc;
    logic [4:0]  rd;
    logic [31:0] rd_data;
    logic [31:0] csr_wdata;
    logic [31:0] store_data;
    logic        mispredict; // npc is not pc plus 4.
  } exec_res_t;

endpackage

// File: hw/exu_stage.sv
`timescale 1ns/1ps

module exu_stage import exu_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      issue_valid,
  input  exec_req_t issue_req,
  output logic      issue_ready,
  input  logic      block,
  output logic      execute_valid,
  output exec_res_t res
);

  alu_op_t     alu_op_q;
  logic [31:0] operand1;
  logic [31:0] operand2;
  logic [31:0] alu_result;
  logic [31:0] csr_operand;
  logic [31:0] snpc;
  logic [31:0] dnpc;
  logic [31:0] pc_q;
  logic [31:0] csr_src_q;
  logic [31:0] store_data_q;
  logic [4:0]  rd_q;
  npc_sel_t    npc_sel_q;
  wdata_sel_t  wdata_sel_q;
  logic [31:0] npc;

  alu u_alu (
    .op     (alu_op_q),
    .a      (operand1),
    .b      (operand2),
    .result (alu_result)
  );

  assign issue_ready = !block;

  always_comb begin
    case (issue_req.csr_op)
      csr_write: csr_operand = issue_req.src1;
      csr_set:   csr_operand = issue_req.src1 | issue_req.csr_src;
      csr_clear: csr_operand = issue_req.csr_src & ~issue_req.src1;
      default:   csr_operand = issue_req.csr_src;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      execute_valid <= 1'b0;
    end else if (!block) begin
      execute_valid <= issue_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (!block) begin
      alu_op_q <= issue_req.alu_op;
      case (issue_req.op1_sel)
        op1_pc:   operand1 <= issue_req.pc;
        op1_zero: operand1 <= 32'd0;
        default:  operand1 <= issue_req.src1;
      endcase
      case (issue_req.op2_sel)
        op2_imm: operand2 <= issue_req.imm;
        op2_csr: operand2 <= csr_operand;
        default: operand2 <= issue_req.src2;
      endcase
      snpc         <= issue_req.pc + 32'd4;
      dnpc         <= issue_req.pc + issue_req.imm;
      pc_q         <= issue_req.pc;
      csr_src_q    <= issue_req.csr_src;
      store_data_q <= issue_req.src2;
      rd_q         <= issue_req.rd;
      npc_sel_q    <= issue_req.npc_sel;
      wdata_sel_q  <= issue_req.wdata_sel;
    end
  end

  always_comb begin
    case (npc_sel_q)
      npc_jal:    npc = dnpc;
      npc_jalr:   npc = alu_result & ~32'd1;
      npc_branch: npc = alu_result[0] ? dnpc : snpc; // taken when compare is 1.
      default:    npc = snpc;
    endcase
    res.pc  = pc_q;
    res.npc = npc;
    res.rd  = rd_q;
    case (wdata_sel_q)
      wdata_snpc: res.rd_data = snpc; // jal, jalr.
      wdata_dnpc: res.rd_data = dnpc; // auipc.
      wdata_csr:  res.rd_data = csr_src_q; // old csr value.
      default:    res.rd_data = alu_result;
    endcase
    res.csr_wdata  = alu_result;
    res.store_data = store_data_q;
    res.mispredict = (npc != snpc);
  end

endmodule

// File: hw/exu_top.sv
`timescale 1ns/1ps

module exu_top import exu_pkg::*; #(
  parameter int queue_depth = 4
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      inst_valid,
  output logic      inst_ready,
  input  inst_in_t  inst,
  input  logic      hold,
  output logic      retire_valid,
  output exec_res_t retire,
  output logic      wrong_prediction
);

  logic      req_valid;
  logic      req_ready;
  exec_req_t req;
  logic      issue_valid;
  logic      issue_ready;
  exec_req_t issue_req;
  logic      block;
  logic      execute_valid;
  exec_res_t res;

  inst_decoder u_decoder (
    .in_valid  (inst_valid),
    .in_inst   (inst),
    .in_ready  (inst_ready),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready)
  );

  issue_fifo #(
    .queue_depth (queue_depth)
  ) u_queue (
    .clock    (clock),
    .reset    (reset),
    .wr_valid (req_valid),
    .wr_ready (req_ready),
    .wr_data  (req),
    .rd_valid (issue_valid),
    .rd_ready (issue_ready),
    .rd_data  (issue_req)
  );

  exu_stage u_exu (
    .clock         (clock),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .issue_req     (issue_req),
    .issue_ready   (issue_ready),
    .block         (block),
    .execute_valid (execute_valid),
    .res           (res)
  );

  retire_unit u_retire (
    .clock            (clock),
    .reset            (reset),
    .hold             (hold),
    .execute_valid    (execute_valid),
    .res_in           (res),
    .block            (block),
    .retire_valid     (retire_valid),
    .retire           (retire),
    .wrong_prediction (wrong_prediction)
  );

endmodule

// File: hw/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import exu_pkg::*; (
  input  logic      in_valid,
  input  inst_in_t  in_inst,
  output logic      in_ready,
  output logic      req_valid,
  output exec_req_t req,
  input  logic      req_ready
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic        alt; // sub and sra.
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  alu_op_t     arith_op;
  alu_op_t     cmp_op;

  assign opcode = in_inst.inst[6:0];
  assign funct3 = in_inst.inst[14:12];
  assign rd     = in_inst.inst[11:7];
  assign rs1    = in_inst.inst[19:15];
  assign alt    = in_inst.inst[30] && (opcode == opc_op || funct3 == 3'b101);

  assign imm_i = {{20{in_inst.inst[31]}}, in_inst.inst[31:20]};
  assign imm_s = {{20{in_inst.inst[31]}}, in_inst.inst[31:25], in_inst.inst[11:7]};
  assign imm_b = {{19{in_inst.inst[31]}}, in_inst.inst[31], in_inst.inst[7],
                  in_inst.inst[30:25], in_inst.inst[11:8], 1'b0};
  assign imm_u = {in_inst.inst[31:12], 12'd0};
  assign imm_j = {{11{in_inst.inst[31]}}, in_inst.inst[31], in_inst.inst[19:12],
                  in_inst.inst[20], in_inst.inst[30:21], 1'b0};

  assign in_ready  = req_ready; // queue space.
  assign req_valid = in_valid;

  always_comb begin
    case (funct3)
      3'b000:  arith_op = alt ? alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b011:  arith_op = alu_sltu;
      3'b100:  arith_op = alu_xor;
      3'b101:  arith_op = alt ? alu_sra : alu_srl;
      3'b110:  arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
    case (funct3)
      3'b000:  cmp_op = alu_eq;
      3'b001:  cmp_op = alu_ne;
      3'b100:  cmp_op = alu_lt;
      3'b101:  cmp_op = alu_ge;
      3'b110:  cmp_op = alu_ltu;
      default: cmp_op = alu_geu;
    endcase
  end

  always_comb begin
    req           = '0; // unknown opcodes become an add to x0.
    req.pc        = in_inst.pc;
    req.src1      = in_inst.src1;
    req.src2      = in_inst.src2;
    req.csr_src   = in_inst.csr_src;
    req.alu_op    = alu_add;
    req.op1_sel   = op1_src1;
    req.op2_sel   = op2_src2;
    req.npc_sel   = npc_seq;
    req.wdata_sel = wdata_alu;
    req.csr_op    = csr_none;
    case (opcode)
      opc_op: begin
        req.rd     = rd;
        req.alu_op = arith_op;
      end
      opc_op_imm: begin
        req.rd      = rd;
        req.alu_op  = arith_op;
        req.imm     = imm_i;
        req.op2_sel = op2_imm;
      end
      opc_lui: begin
        req.rd      = rd;
        req.alu_op  = alu_pass_b;
        req.imm     = imm_u;
        req.op2_sel = op2_imm;
      end
      opc_auipc: begin
        req.rd        = rd;
        req.imm       = imm_u;
        req.op1_sel   = op1_pc;
        req.op2_sel   = op2_imm;
        req.wdata_sel = wdata_dnpc;
      end
      opc_jal: begin
        req.rd        = rd;
        req.imm       = imm_j;
        req.npc_sel   = npc_jal;
        req.wdata_sel = wdata_snpc;
      end
      opc_jalr: begin
        req.rd        = rd;
        req.imm       = imm_i;
        req.op2_sel   = op2_imm;
        req.npc_sel   = npc_jalr;
        req.wdata_sel = wdata_snpc;
      end
      opc_branch: begin
        if (funct3[2:1] != 2'b01) begin
          req.imm     = imm_b;
          req.alu_op  = cmp_op;
          req.npc_sel = npc_branch;
        end
      end
      opc_store: begin
        req.imm     = imm_s; // address in rd_data, nothing written.
        req.op2_sel = op2_imm;
      end
      opc_system: begin
        if (funct3[1:0] != 2'b00) begin
          req.rd        = rd;
          req.alu_op    = alu_pass_b;
          req.op2_sel   = op2_csr;
          req.wdata_sel = wdata_csr;
          req.csr_op    = csr_op_t'(funct3[1:0]);
          if (funct3[2]) req.src1 = {27'd0, rs1}; // zimm forms.
        end
      end
      default: ;
    endcase
  end

endmodule

// File: hw/issue_fifo.sv
`timescale 1ns/1ps

module issue_fifo import exu_pkg::*; #(
  parameter int queue_depth = 4
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      wr_valid,
  output logic      wr_ready,
  input  exec_req_t wr_data,
  output logic      rd_valid,
  input  logic      rd_ready,
  output exec_req_t rd_data
);

  localparam int addr_w = $clog2(queue_depth);

  exec_req_t         mem [queue_depth];
  logic [addr_w:0]   wr_ptr; // top bit tells full from empty.
  logic [addr_w:0]   rd_ptr;
  logic              full;
  logic              empty;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                 (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

  assign wr_ready = !full || rd_ready; // a read frees the slot this edge.
  assign rd_valid = !empty;
  assign rd_data  = mem[rd_ptr[addr_w-1:0]];

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_valid && wr_ready) wr_ptr <= wr_ptr + 1'b1;
      if (rd_valid && rd_ready) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_valid && wr_ready) mem[wr_ptr[addr_w-1:0]] <= wr_data;
  end

endmodule

// File: hw/retire_unit.sv
`timescale 1ns/1ps

module retire_unit import exu_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      hold,
  input  logic      execute_valid,
  input  exec_res_t res_in,
  output logic      block,
  output logic      retire_valid,
  output exec_res_t retire,
  output logic      wrong_prediction
);

  logic [31:0] expected_pc;
  logic        on_path;

  assign block   = hold; // freezes the execute stage and the queue head.
  assign on_path = execute_valid && (res_in.pc == expected_pc);

  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid     <= 1'b0;
      wrong_prediction <= 1'b0;
      expected_pc      <= reset_pc;
    end else if (hold) begin
      retire_valid     <= 1'b0;
      wrong_prediction <= 1'b0;
    end else begin
      retire_valid     <= on_path; // wrong-path results are dropped here.
      wrong_prediction <= on_path && res_in.mispredict;
      if (on_path) expected_pc <= res_in.npc;
    end
  end

  always_ff @(posedge clock) begin
    if (!hold && on_path) retire <= res_in;
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execute subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -sv -f vlog.f --top-module exu_tb -o exu_sim

# A failing run exits through $fatal; keep its output for the search below.
output=$(./obj_dir/exu_sim 2>&1 || true)
echo "$output"

if grep -qx "NO ERRORS" <<< "$output"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// File: verif/exu_tb.sv
`timescale 1ns/1ps

module exu_tb import exu_pkg::*; ();

  localparam int num_tests    = 29;
  localparam int clock_period = 20;
  localparam int max_cycles   = 2 * (num_tests * 200 + 32); // two passes.

  logic            clock;
  logic            reset;
  logic            inst_valid;
  logic            inst_ready;
  inst_in_t        inst;
  logic            hold;
  logic            retire_valid;
  exec_res_t       retire;
  logic            wrong_prediction;

  logic [31:0]     tests [num_tests * 8];
  int              expected_q [$];
  int              seed;
  bit              noise;
  bit              ready_fell;
  int              base;

  exu_top #(
    .queue_depth (4)
  ) UUT (
    .clock            (clock),
    .reset            (reset),
    .inst_valid       (inst_valid),
    .inst_ready       (inst_ready),
    .inst             (inst),
    .hold             (hold),
    .retire_valid     (retire_valid),
    .retire           (retire),
    .wrong_prediction (wrong_prediction)
  );

  always #(clock_period / 2) clock = ~clock;

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    string line;
    if (actual !== expected) begin
      line = $sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, actual,
                       expected);
      stop_on_error(line);
    end
  endtask

  // branches, stores and unknown opcodes write no register.
  function automatic logic [31:0] dest_reg(input logic [31:0] word);
    logic [31:0] rd;
    rd = 32'd0;
    case (word[6:0])
      opc_op, opc_op_imm, opc_lui, opc_auipc, opc_jal, opc_jalr, opc_system:
        rd = {27'd0, word[11:7]};
      default: ;
    endcase
    return rd;
  endfunction

  task automatic check_idle_outputs();
    check_value("retire_valid", {31'd0, retire_valid}, 32'd0);
    check_value("wrong_prediction", {31'd0, wrong_prediction}, 32'd0);
    check_value("inst_ready", {31'd0, inst_ready}, 32'd1);
  endtask

  // wait one clock and draw a new hold when back-pressure is on.
  task automatic next_cycle();
    @(posedge clock);
    #1;
    if (noise) hold = (($random(seed) & 32'h3) != 0);
  endtask

  task automatic apply_reset();
    reset      = 1'b1;
    inst_valid = 1'b0;
    hold       = 1'b0;
    repeat (16) begin
      @(posedge clock);
      #1;
      check_idle_outputs();
    end
    reset = 1'b0;
    @(negedge clock);
    check_idle_outputs();
  endtask

  // wrong-path lines drop out as the pc chain is followed from reset_pc.
  task automatic build_expected();
    logic [31:0] chain_pc;
    chain_pc = 32'd0;
    expected_q.delete();
    for (int i = 0; i < num_tests; i++) begin
      if (tests[i * 8] == chain_pc) begin
        expected_q.push_back(i);
        chain_pc = tests[i * 8 + 6];
      end
    end
  endtask

  task automatic send_line(input int idx);
    logic ready_seen;
    inst.pc      = tests[idx * 8];
    inst.inst    = tests[idx * 8 + 1];
    inst.src1    = tests[idx * 8 + 2];
    inst.src2    = tests[idx * 8 + 3];
    inst.csr_src = tests[idx * 8 + 4];
    inst_valid   = 1'b1;
    ready_seen   = 1'b0;
    while (!ready_seen) begin
      @(negedge clock);
      ready_seen = inst_ready; // inputs stay put until the next edge.
      next_cycle();
    end
  endtask

  task automatic run_pass(input bit with_noise);
    int gap;
    apply_reset();
    build_expected();
    ready_fell = 1'b0;
    noise      = with_noise;
    for (int i = 0; i < num_tests; i++) begin
      if (noise && (($random(seed) & 32'h7) == 0)) begin
        gap        = 1 + ($random(seed) & 32'h1);
        inst_valid = 1'b0;
        repeat (gap) next_cycle();
      end
      send_line(i);
    end
    inst_valid = 1'b0;
    noise      = 1'b0;
    hold       = 1'b0;
    while (expected_q.size() != 0) next_cycle();
    repeat (4) next_cycle(); // a stray retirement would show here.
    if (with_noise && !ready_fell)
      stop_on_error("hold never filled the queue, inst_ready stayed high");
  endtask

  always @(negedge clock) begin
    if (!reset) begin
      if (!hold) check_value("inst_ready", {31'd0, inst_ready}, 32'd1);
      if (!inst_ready) ready_fell = 1'b1;
      if (retire_valid) begin
        if (expected_q.size() == 0) begin
          stop_on_error("a result retired when no instruction was expected");
        end else begin
          base = expected_q.pop_front() * 8;
          check_value("retire.pc", retire.pc, tests[base]);
          check_value("retire.npc", retire.npc, tests[base + 6]);
          check_value("retire.rd", {27'd0, retire.rd}, dest_reg(tests[base + 1]));
          check_value("retire.rd_data", retire.rd_data, tests[base + 5]);
          check_value("retire.csr_wdata", retire.csr_wdata, tests[base + 7]);
          check_value("retire.store_data", retire.store_data, tests[base + 3]);
          check_value("retire.mispredict", {31'd0, retire.mispredict},
                      {31'd0, tests[base + 6] != tests[base] + 32'd4});
          check_value("wrong_prediction", {31'd0, wrong_prediction},
                      {31'd0, tests[base + 6] != tests[base] + 32'd4});
        end
      end
    end
  end

  initial begin
    #(max_cycles * clock_period);
    stop_on_error("timeout, the retire stream did not finish in time");
  end

  initial begin
    clock      = 1'b0;
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    hold       = 1'b0;
    noise      = 1'b0;
    ready_fell = 1'b0;
    seed       = 32'h043a1f19;
    $readmemh("verif/exu_tests.txt", tests);
    run_pass(1'b0);
    run_pass(1'b1); // random hold and input gaps.
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: verif/exu_tests.txt
// pc inst src1 src2 csr_src rd_data npc csr_wdata
// lines whose pc breaks the chain are wrong-path and never retire
00000000 002081B3 00000005 00000007 00000000 0000000C 00000004 0000000C
00000004 40208233 00000010 00000003 00000000 0000000D 00000008 0000000D
00000008 002092B3 00000001 00000024 00000000 00000010 0000000C 00000010
0000000C 0020A333 FFFFFFFF 00000001 00000000 00000001 00000010 00000001
00000010 0020B3B3 FFFFFFFF 00000001 00000000 00000000 00000014 00000000
00000014 0020C433 F0F0F0F0 FF00FF00 00000000 0FF00FF0 00000018 0FF00FF0
00000018 0020D4B3 80000000 00000004 00000000 08000000 0000001C 08000000
0000001C 4020D533 80000000 00000004 00000000 F8000000 00000020 F8000000
00000020 0020E5B3 000000F0 00000F00 00000000 00000FF0 00000024 00000FF0
00000024 0020F633 12345678 0000FFFF 00000000 00005678 00000028 00005678
00000028 FFF08693 00000010 00000000 00000000 0000000F 0000002C 0000000F
0000002C 4030D713 FFFFFF00 00000000 00000000 FFFFFFE0 00000030 FFFFFFE0
00000030 123457B7 00000000 00000000 00000000 12345000 00000034 12345000
00000034 00001817 00000000 00000000 00000000 00001034 00000038 00001034
00000038 010000EF 00000000 00000000 00000000 0000003C 00000048 00000000
0000003C 00100113 00000000 00000000 00000000 00000001 00000040 00000001
00000040 002081B3 00000001 00000001 00000000 00000002 00000044 00000002
00000048 006082E7 000000FB 00000000 00000000 0000004C 00000100 00000101
0000004C 00100113 00000000 00000000 00000000 00000001 00000050 00000001
00000100 00208463 00000055 00000055 00000000 00000001 00000108 00000001
00000104 002081B3 00000002 00000002 00000000 00000004 00000108 00000004
00000108 FE209CE3 00000055 00000055 00000000 00000000 0000010C 00000000
0000010C 0020C663 FFFFFFFF 00000001 00000000 00000001 00000118 00000001
00000110 002081B3 00000003 00000003 00000000 00000006 00000114 00000006
00000118 0020F463 00000001 FFFFFFFF 00000000 00000000 0000011C 00000000
0000011C 30009373 AAAA0000 00000000 0000BBBB 0000BBBB 00000120 AAAA0000
00000120 3000A3F3 000000F0 00000000 0000000F 0000000F 00000124 000000FF
00000124 3000B473 0000000F 00000000 000000FF 000000FF 00000128 000000F0
00000128 0020A423 00001000 DEADBEEF 00000000 00001008 0000012C 00001008

// File: vlog.f
hw/exu_pkg.sv
hw/alu.sv
hw/inst_decoder.sv
hw/issue_fifo.sv
hw/exu_stage.sv
hw/retire_unit.sv
hw/exu_top.sv
verif/exu_tb.sv
